// File: rtl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// word and register file size
`define CPU_DATA_W      16
`define CPU_REG_COUNT   8

// pc after reset
`define CPU_RESET_PC    16'h0000

// bit positions in the flag word
`define CPU_FLAG_GREATER   15
`define CPU_FLAG_LESSER    14
`define CPU_FLAG_EQUAL     13
`define CPU_FLAG_ZERO      12
`define CPU_FLAG_CARRY     11
`define CPU_FLAG_OVERFLOW  10
`define CPU_FLAG_DIVZERO   9
`define CPU_FLAG_NEGATIVE  6

// outchar colour adjustment
`define CPU_COLOR_STEP  16'h0F00

`endif

// File: rtl/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

   typedef logic [`CPU_DATA_W-1:0] word_t;
   typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;

   // instruction bits 15..10
   typedef enum logic [5:0] {
      LOAD    = 6'b110000,
      STORE   = 6'b110001,
      OUTCHAR = 6'b110010,
      MOV     = 6'b110011,
      LOADN   = 6'b111000,
      LOADI   = 6'b111100,
      STOREI  = 6'b111101,
      JMP     = 6'b000010
   } opcode_e;

   // instruction bits 9..6, code 15 left unnamed
   typedef enum logic [3:0] {
      ALWAYS, EQ, NE, ZERO, NOT_ZERO, CARRY, NOT_CARRY,
      GREATER, LESSER, GREATER_EQ, LESSER_EQ,
      OVERFLOW, NOT_OVERFLOW, NEGATIVE, DIV_ZERO
   } cond_e;

   typedef enum logic [2:0] {
      FETCH, DECODE, OPERAND, ADDRESS, ACCESS, FINISH
   } seq_state_e;

endpackage

// File: rtl/register_file.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module register_file (
   input  logic              wire_clock,
   input  logic              resetStage,
   input  cpu_pkg::reg_idx_t rd_a_idx,
   input  cpu_pkg::reg_idx_t rd_b_idx,
   output cpu_pkg::word_t    rd_a_data,
   output cpu_pkg::word_t    rd_b_data,
   input  logic              wr_en,
   input  cpu_pkg::reg_idx_t wr_idx,
   input  cpu_pkg::word_t    wr_data
);

   cpu_pkg::word_t regs [`CPU_REG_COUNT];

   always_ff @(posedge wire_clock) begin
      if (resetStage) begin
         for (int i = 0; i < `CPU_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   // reads see the old value during a write cycle
   assign rd_a_data = regs[rd_a_idx];
   assign rd_b_data = regs[rd_b_idx];

endmodule

// File: rtl/branch_condition.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module branch_condition (
   input  cpu_pkg::cond_e cond,
   input  cpu_pkg::word_t flags,
   output logic           taken
);

   logic flag_greater;
   logic flag_lesser;
   logic flag_equal;
   logic flag_zero;
   logic flag_carry;
   logic flag_overflow;
   logic flag_divzero;
   logic flag_negative;

   assign flag_greater  = flags[`CPU_FLAG_GREATER];
   assign flag_lesser   = flags[`CPU_FLAG_LESSER];
   assign flag_equal    = flags[`CPU_FLAG_EQUAL];
   assign flag_zero     = flags[`CPU_FLAG_ZERO];
   assign flag_carry    = flags[`CPU_FLAG_CARRY];
   assign flag_overflow = flags[`CPU_FLAG_OVERFLOW];
   assign flag_divzero  = flags[`CPU_FLAG_DIVZERO];
   assign flag_negative = flags[`CPU_FLAG_NEGATIVE];

   always_comb begin
      case (cond)
         cpu_pkg::ALWAYS:       taken = 1'b1;
         cpu_pkg::EQ:           taken = flag_equal;
         cpu_pkg::NE:           taken = !flag_equal;
         cpu_pkg::ZERO:         taken = flag_zero;
         cpu_pkg::NOT_ZERO:     taken = !flag_zero;
         cpu_pkg::CARRY:        taken = flag_carry;
         cpu_pkg::NOT_CARRY:    taken = !flag_carry;
         cpu_pkg::GREATER:      taken = flag_greater;
         cpu_pkg::LESSER:       taken = flag_lesser;
         cpu_pkg::GREATER_EQ:   taken = flag_greater | flag_equal;
         cpu_pkg::LESSER_EQ:    taken = flag_lesser | flag_equal;
         cpu_pkg::OVERFLOW:     taken = flag_overflow;
         cpu_pkg::NOT_OVERFLOW: taken = !flag_overflow;
         cpu_pkg::NEGATIVE:     taken = flag_negative;
         cpu_pkg::DIV_ZERO:     taken = flag_divzero;
         // code 15
         default:               taken = 1'b0;
      endcase
   end

endmodule

// File: rtl/video_port.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module video_port (
   input  logic           wire_clock,
   input  logic           resetStage,
   input  logic           video_load,
   input  cpu_pkg::word_t load_pos,
   input  cpu_pkg::word_t load_char,
   output cpu_pkg::word_t video_pos,
   output cpu_pkg::word_t video_char,
   output logic           video_strobe
);

   cpu_pkg::word_t adj_char;

   // colour nibble 0 steps up, F steps down
   always_comb begin
      if (load_char[11:8] == 4'h0) begin
         adj_char = load_char + `CPU_COLOR_STEP;
      end else if (load_char[11:8] == 4'hF) begin
         adj_char = load_char - `CPU_COLOR_STEP;
      end else begin
         adj_char = load_char;
      end
   end

   always_ff @(posedge wire_clock) begin
      if (video_load) begin
         video_pos  <= load_pos;
         video_char <= adj_char;
      end
   end

   always_ff @(posedge wire_clock) begin
      if (resetStage) begin
         video_strobe <= 1'b0;
      end else begin
         video_strobe <= video_load;
      end
   end

endmodule

// File: rtl/instruction_sequencer.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module instruction_sequencer (
   input  logic              wire_clock,
   input  logic              resetStage,
   input  cpu_pkg::word_t    mem_rdata,
   output cpu_pkg::word_t    mem_addr,
   output cpu_pkg::word_t    mem_wdata,
   output logic              mem_write,
   output cpu_pkg::reg_idx_t rd_a_idx,
   output cpu_pkg::reg_idx_t rd_b_idx,
   input  cpu_pkg::word_t    rd_a_data,
   input  cpu_pkg::word_t    rd_b_data,
   output logic              wr_en,
   output cpu_pkg::reg_idx_t wr_idx,
   output cpu_pkg::word_t    wr_data,
   output cpu_pkg::cond_e    cond,
   input  logic              taken,
   output logic              video_load,
   output cpu_pkg::word_t    load_pos,
   output cpu_pkg::word_t    load_char
);

   cpu_pkg::seq_state_e state;
   cpu_pkg::word_t      pc;
   cpu_pkg::word_t      ir;
   cpu_pkg::word_t      addr_reg;
   cpu_pkg::word_t      pc_inc;
   cpu_pkg::word_t      pc_next;
   cpu_pkg::opcode_e    op;
   cpu_pkg::opcode_e    fetch_op;

   assign op       = cpu_pkg::opcode_e'(ir[15:10]);
   assign fetch_op = cpu_pkg::opcode_e'(mem_rdata[15:10]);
   assign cond     = cpu_pkg::cond_e'(ir[9:6]);
   assign pc_inc   = pc + 1'b1;

   // in DECODE the instruction is still on the memory bus
   assign rd_a_idx = (state == cpu_pkg::DECODE) ? mem_rdata[9:7] : ir[9:7];
   assign rd_b_idx = (state == cpu_pkg::DECODE) ? mem_rdata[6:4] : ir[6:4];

   // jump target or operand skip
   always_comb begin
      case (op)
         cpu_pkg::LOADN: pc_next = pc_inc;
         cpu_pkg::JMP:   pc_next = taken ? mem_rdata : pc_inc;
         default:        pc_next = pc;
      endcase
   end

   always_ff @(posedge wire_clock) begin
      if (resetStage) begin
         state    <= cpu_pkg::FETCH;
         pc       <= `CPU_RESET_PC;
         mem_addr <= `CPU_RESET_PC;
      end else begin
         case (state)
            cpu_pkg::FETCH: begin
               state <= cpu_pkg::DECODE;
            end
            cpu_pkg::DECODE: begin
               pc    <= pc_inc;
               state <= cpu_pkg::OPERAND;
               case (fetch_op)
                  cpu_pkg::LOADI:  mem_addr <= rd_b_data;
                  cpu_pkg::STOREI: mem_addr <= rd_a_data;
                  default:         mem_addr <= pc_inc;
               endcase
            end
            cpu_pkg::OPERAND: begin
               case (op)
                  cpu_pkg::LOAD, cpu_pkg::STORE: begin
                     state <= cpu_pkg::ADDRESS;
                  end
                  cpu_pkg::OUTCHAR: begin
                     mem_addr <= pc;
                     state    <= cpu_pkg::FINISH;
                  end
                  default: begin
                     pc       <= pc_next;
                     mem_addr <= pc_next;
                     state    <= cpu_pkg::FETCH;
                  end
               endcase
            end
            cpu_pkg::ADDRESS: begin
               mem_addr <= addr_reg;
               state    <= cpu_pkg::ACCESS;
            end
            cpu_pkg::ACCESS: begin
               // step over the address word
               pc       <= pc_inc;
               mem_addr <= pc_inc;
               state    <= cpu_pkg::FETCH;
            end
            default: begin
               state <= cpu_pkg::FETCH;
            end
         endcase
      end
   end

   always_ff @(posedge wire_clock) begin
      if (state == cpu_pkg::DECODE) begin
         ir <= mem_rdata;
      end
      if (state == cpu_pkg::OPERAND) begin
         addr_reg <= mem_rdata;
      end
   end

   assign mem_write = ((state == cpu_pkg::ACCESS) && (op == cpu_pkg::STORE)) ||
                      ((state == cpu_pkg::OPERAND) && (op == cpu_pkg::STOREI));
   assign mem_wdata = (op == cpu_pkg::STOREI) ? rd_b_data : rd_a_data;

   assign wr_en = ((state == cpu_pkg::OPERAND) &&
                   ((op == cpu_pkg::LOADN) || (op == cpu_pkg::LOADI) ||
                    (op == cpu_pkg::MOV))) ||
                  ((state == cpu_pkg::ACCESS) && (op == cpu_pkg::LOAD));
   assign wr_idx  = ir[9:7];
   assign wr_data = (op == cpu_pkg::MOV) ? rd_b_data : mem_rdata;

   // position from ry, character from rx
   assign video_load = (state == cpu_pkg::OPERAND) && (op == cpu_pkg::OUTCHAR);
   assign load_pos   = rd_b_data;
   assign load_char  = rd_a_data;

endmodule

// File: rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
   input  logic           wire_clock,
   input  logic           resetStage,
   input  cpu_pkg::word_t mem_rdata,
   output cpu_pkg::word_t mem_addr,
   output cpu_pkg::word_t mem_wdata,
   output logic           mem_write,
   input  cpu_pkg::word_t flags,
   output cpu_pkg::word_t video_pos,
   output cpu_pkg::word_t video_char,
   output logic           video_strobe
);

   cpu_pkg::reg_idx_t rd_a_idx;
   cpu_pkg::reg_idx_t rd_b_idx;
   cpu_pkg::word_t    rd_a_data;
   cpu_pkg::word_t    rd_b_data;
   logic              wr_en;
   cpu_pkg::reg_idx_t wr_idx;
   cpu_pkg::word_t    wr_data;
   cpu_pkg::cond_e    cond;
   logic              taken;
   logic              video_load;
   cpu_pkg::word_t    load_pos;
   cpu_pkg::word_t    load_char;

   instruction_sequencer u_seq (
      .wire_clock(wire_clock), .resetStage(resetStage),
      .mem_rdata(mem_rdata), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_write(mem_write),
      .rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx),
      .rd_a_data(rd_a_data), .rd_b_data(rd_b_data),
      .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
      .cond(cond), .taken(taken),
      .video_load(video_load), .load_pos(load_pos), .load_char(load_char)
   );

   register_file u_regs (
      .wire_clock(wire_clock), .resetStage(resetStage),
      .rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx),
      .rd_a_data(rd_a_data), .rd_b_data(rd_b_data),
      .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
   );

   branch_condition u_branch (.cond(cond), .flags(flags), .taken(taken));

   video_port u_video (
      .wire_clock(wire_clock), .resetStage(resetStage),
      .video_load(video_load), .load_pos(load_pos), .load_char(load_char),
      .video_pos(video_pos), .video_char(video_char), .video_strobe(video_strobe)
   );

endmodule

// File: verification/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

   localparam int EVENT_TIMEOUT = 300;
   localparam int DRAIN_CYCLES  = 8;
   localparam int RESET_CYCLES  = 5;

   logic           wire_clock;
   logic           resetStage;
   cpu_pkg::word_t mem_rdata;
   cpu_pkg::word_t mem_addr;
   cpu_pkg::word_t mem_wdata;
   logic           mem_write;
   cpu_pkg::word_t flags;
   cpu_pkg::word_t video_pos;
   cpu_pkg::word_t video_char;
   logic           video_strobe;

   cpu_pkg::word_t mem [0:65535];

   // expected events, in order, per kind
   cpu_pkg::word_t exp_w_addr [$];
   cpu_pkg::word_t exp_w_data [$];
   cpu_pkg::word_t exp_v_pos [$];
   cpu_pkg::word_t exp_v_char [$];

   string          test_name;
   cpu_pkg::word_t test_flags;
   int             tests_run;

   cpu_top DUT (
      .wire_clock(wire_clock), .resetStage(resetStage),
      .mem_rdata(mem_rdata), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .mem_write(mem_write),
      .flags(flags),
      .video_pos(video_pos), .video_char(video_char), .video_strobe(video_strobe)
   );

   // combinational read, write at the edge
   assign mem_rdata = mem[mem_addr];

   always @(posedge wire_clock) begin
      if (mem_write) begin
         mem[mem_addr] <= mem_wdata;
      end
   end

   initial begin
      wire_clock = 1'b0;
      forever #20 wire_clock = ~wire_clock;
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_write(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
      cpu_pkg::word_t exp_addr;
      cpu_pkg::word_t exp_data;
      if (exp_w_addr.size() == 0) begin
         stop_run($sformatf("test %s: unexpected memory write of %h to %h",
                            test_name, data, addr));
      end else begin
         exp_addr = exp_w_addr.pop_front();
         exp_data = exp_w_data.pop_front();
         if (addr !== exp_addr || data !== exp_data) begin
            $display("[ERROR] %s: write expected addr %h data %h, actual addr %h data %h",
                     test_name, exp_addr, exp_data, addr, data);
            stop_run("memory write does not match");
         end
      end
   endtask

   task automatic check_video(input cpu_pkg::word_t pos, input cpu_pkg::word_t char);
      cpu_pkg::word_t exp_pos;
      cpu_pkg::word_t exp_char;
      if (exp_v_pos.size() == 0) begin
         stop_run($sformatf("test %s: unexpected video event at %h", test_name, pos));
      end else begin
         exp_pos  = exp_v_pos.pop_front();
         exp_char = exp_v_char.pop_front();
         if (pos !== exp_pos || char !== exp_char) begin
            $display("[ERROR] %s: video expected pos %h char %h, actual pos %h char %h",
                     test_name, exp_pos, exp_char, pos, char);
            stop_run("video event does not match");
         end
      end
   endtask

   task automatic run_test;
      int wait_cycles;
      @(posedge wire_clock);
      #2;
      flags      = test_flags;
      resetStage = 1'b1;
      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(posedge wire_clock);
         #1;
         if (mem_write !== 1'b0 || video_strobe !== 1'b0) begin
            stop_run($sformatf("test %s: write or strobe active during reset", test_name));
         end
         #1;
      end
      resetStage  = 1'b0;
      wait_cycles = 0;
      while (exp_w_addr.size() + exp_v_pos.size() > 0) begin
         @(posedge wire_clock);
         #1;
         if (mem_write === 1'b1) begin
            check_write(mem_addr, mem_wdata);
         end
         if (video_strobe === 1'b1) begin
            check_video(video_pos, video_char);
         end
         wait_cycles++;
         if (wait_cycles > EVENT_TIMEOUT) begin
            stop_run($sformatf("test %s: timed out waiting for expected events", test_name));
         end
      end
      // nothing more may follow the last expected event
      for (int i = 0; i < DRAIN_CYCLES; i++) begin
         @(posedge wire_clock);
         #1;
         if (mem_write !== 1'b0 || video_strobe !== 1'b0) begin
            stop_run($sformatf("test %s: event left over after the last expected one",
                               test_name));
         end
      end
      tests_run++;
   endtask

   initial begin
      int             fd;
      string          tok;
      string          rest;
      cpu_pkg::word_t a;
      cpu_pkg::word_t d [4];
      resetStage = 1'b1;
      flags      = '0;
      tests_run  = 0;
      test_name  = "none";
      fd = $fopen("verification/cpu_golden.txt", "r");
      if (fd == 0) begin
         stop_run("cannot open verification/cpu_golden.txt");
      end
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok.substr(0, 0) == "#") begin
            void'($fgets(rest, fd));
         end else if (tok == "T") begin
            void'($fscanf(fd, "%s %h", test_name, test_flags));
            for (int i = 0; i < 65536; i++) begin
               mem[i] <= '0;
            end
            exp_w_addr.delete();
            exp_w_data.delete();
            exp_v_pos.delete();
            exp_v_char.delete();
         end else if (tok == "M") begin
            void'($fscanf(fd, "%h %h %h %h %h", a, d[0], d[1], d[2], d[3]));
            for (int i = 0; i < 4; i++) begin
               mem[a + i] <= d[i];
            end
         end else if (tok == "W") begin
            void'($fscanf(fd, "%h %h", d[0], d[1]));
            exp_w_addr.push_back(d[0]);
            exp_w_data.push_back(d[1]);
         end else if (tok == "V") begin
            void'($fscanf(fd, "%h %h", d[0], d[1]));
            exp_v_pos.push_back(d[0]);
            exp_v_char.push_back(d[1]);
         end else if (tok == "E") begin
            run_test();
         end else begin
            stop_run($sformatf("unknown record %s in golden file", tok));
         end
      end
      $fclose(fd);
      if (tests_run > 0) begin
         $display("Everything OK");
         $finish;
      end else begin
         stop_run("golden file holds no test");
      end
   end

endmodule

// File: verification/cpu_golden.txt
# T name flags | M addr w0 w1 w2 w3 (four memory words from addr)
# W addr data (expected write) | V pos char (expected video) | E runs the test
T loadn_load_store 0000
M 0000 E080 00A5 C480 0100
M 0004 C100 0030 C500 0101
M 0030 1234 0000 0000 0000
W 0100 00A5
W 0101 1234
E
T loadi_mov_storei 0000
M 0000 E080 0200 E100 0050
M 0004 F1A0 CE30 F4C0 0000
M 0050 BEEF 0000 0000 0000
W 0200 BEEF
E
# equal flag set: eq taken, ne not taken, greater_eq taken, code 15 never
T jmp_equal 2000
M 0000 0840 0006 E080 0BAD
M 0004 C480 0100 0880 000C
M 0008 E080 0011 C480 0101
M 000C 0A40 0012 E080 0BAD
M 0010 C480 0102 0BC0 0000
M 0014 E080 0022 C480 0103
W 0101 0011
W 0103 0022
E
# carry flag set: not_carry falls through, carry taken
T jmp_carry 0800
M 0000 0980 0006 E080 0033
M 0004 C480 0104 0940 000C
M 0008 E080 0BAD C480 0105
M 000C E080 0044 C480 0105
W 0104 0033
W 0105 0044
E
T outchar_colour 0000
M 0000 E080 0041 E100 0010
M 0004 C8A0 E180 0F42 E200
M 0008 0011 C9C0 E280 0543
M 000C CAC0 0000 0000 0000
V 0010 0F41
V 0011 0042
V 0011 0543
E
T undefined_opcode 0000
M 0000 E080 0077 C480 0200
M 0004 FC00 C480 0201 0000
W 0200 0077
W 0201 0077
E

// File: project.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/register_file.sv
rtl/branch_condition.sv
rtl/video_port.sv
rtl/instruction_sequencer.sv
rtl/cpu_top.sv
verification/tb_cpu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_cpu -f project.f -o sim_tb_cpu
status=$?
if [ $status -ne 0 ]; then
   echo "build failed"
   exit $status
fi

./obj_dir/sim_tb_cpu
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed"
fi
exit $status
